//--- design/vmicro16_pkg.sv
/* vmicro16 shared definitions
   word types, memory sizes, ISA encodings, ALU operations and core records */
package vmicro16_pkg;

    // widths that carry a meaning
    typedef logic [15:0] data_t;
    typedef logic [15:0] instr_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [5:0]  pc_t;
    typedef logic [5:0]  scratch_addr_t;
    typedef logic [4:0]  funct_t;

    localparam int INSTR_DEPTH   = 64;
    localparam int SCRATCH_DEPTH = 64;
    localparam int NUM_REGS      = 8;

    // major opcode in instr[15:11]
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h04,
        OP_MOVI    = 5'h05,
        OP_ARITH_U = 5'h07,
        OP_ARITH_S = 5'h08,
        OP_HALT    = 5'h0f
    } opcode_t;

    // function codes share instr[4:0] with simm5
    localparam funct_t FN_OR    = 5'h00;
    localparam funct_t FN_XOR   = 5'h01;
    localparam funct_t FN_AND   = 5'h02;
    localparam funct_t FN_NOT   = 5'h03;
    localparam funct_t FN_LSHFT = 5'h04;
    localparam funct_t FN_RSHFT = 5'h05;
    // add and sub are common to ARITH_U and ARITH_S
    localparam funct_t FN_ADD   = 5'b11111;
    localparam funct_t FN_SUB   = 5'b10000;

    typedef enum logic [4:0] {
        ALU_NOP    = 5'd0,
        ALU_PASS_B = 5'd1,
        ALU_OR     = 5'd2,
        ALU_XOR    = 5'd3,
        ALU_AND    = 5'd4,
        ALU_NOT    = 5'd5,
        ALU_SHL    = 5'd6,
        ALU_SHR    = 5'd7,
        ALU_UADD   = 5'd8,
        ALU_USUB   = 5'd9,
        ALU_SADD   = 5'd10,
        ALU_SSUB   = 5'd11
    } alu_op_t;

    // multicycle sequencer
    typedef enum logic [2:0] {
        ST_FETCH   = 3'd0,
        ST_DECODE  = 3'd1,
        ST_EXEC    = 3'd2,
        ST_MEM     = 3'd3,
        ST_WB      = 3'd4,
        ST_HALTED  = 3'd5
    } stage_t;

    typedef struct packed {
        alu_op_t    alu_op;
        reg_sel_t   rd;
        reg_sel_t   ra;
        logic [7:0] imm8;
        logic [4:0] simm5;
        logic       has_imm8;
        logic       has_we;
        logic       has_mem;
        logic       has_mem_we;
        logic       halt;
    } decoded_t;

    typedef struct packed {
        reg_sel_t idx;
        data_t    data;
    } wb_t;

endpackage

//--- design/vmicro16_alu.sv
/* vmicro16 ALU
   combinational bitwise, shift and add/subtract unit */
`timescale 1ns/1ps

module vmicro16_alu (
    input  vmicro16_pkg::alu_op_t op,
    input  vmicro16_pkg::data_t   a,
    input  vmicro16_pkg::data_t   b,
    output vmicro16_pkg::data_t   c
);
    import vmicro16_pkg::*;

    always_comb begin
        case (op)
            ALU_PASS_B: c = b;
            ALU_OR:     c = a | b;
            ALU_XOR:    c = a ^ b;
            ALU_AND:    c = a & b;
            // not works on the second operand only
            ALU_NOT:    c = ~b;
            ALU_SHL:    c = a << b;
            ALU_SHR:    c = a >> b;
            ALU_UADD:   c = a + b;
            ALU_USUB:   c = a - b;
            // signed forms wrap the same way at 16 bits
            ALU_SADD:   c = data_t'($signed(a) + $signed(b));
            ALU_SSUB:   c = data_t'($signed(a) - $signed(b));
            default:    c = '0;
        endcase
    end

endmodule

//--- design/vmicro16_decoder.sv
/* vmicro16 instruction decoder
   splits an instruction word into fields and control flags */
`timescale 1ns/1ps

module vmicro16_decoder (
    input  vmicro16_pkg::instr_t   instr,
    output vmicro16_pkg::decoded_t dec
);
    import vmicro16_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    alu_op_t alu_op;

    assign opcode = opcode_t'(instr[15:11]);
    assign funct  = instr[4:0];

    // operation select, unknown function codes fall back to nop
    always_comb begin
        alu_op = ALU_NOP;
        case (opcode)
            OP_MOV, OP_MOVI: alu_op = ALU_PASS_B;
            OP_BIT: begin
                case (funct)
                    FN_OR:    alu_op = ALU_OR;
                    FN_XOR:   alu_op = ALU_XOR;
                    FN_AND:   alu_op = ALU_AND;
                    FN_NOT:   alu_op = ALU_NOT;
                    FN_LSHFT: alu_op = ALU_SHL;
                    FN_RSHFT: alu_op = ALU_SHR;
                    default:  alu_op = ALU_NOP;
                endcase
            end
            OP_ARITH_U: begin
                if (funct == FN_ADD) begin
                    alu_op = ALU_UADD;
                end else if (funct == FN_SUB) begin
                    alu_op = ALU_USUB;
                end
            end
            OP_ARITH_S: begin
                if (funct == FN_ADD) begin
                    alu_op = ALU_SADD;
                end else if (funct == FN_SUB) begin
                    alu_op = ALU_SSUB;
                end
            end
            default: alu_op = ALU_NOP;
        endcase
    end

    always_comb begin
        dec            = '0;
        dec.alu_op     = alu_op;
        dec.rd         = instr[10:8];
        dec.ra         = instr[7:5];
        dec.imm8       = instr[7:0];
        dec.simm5      = instr[4:0];
        dec.has_imm8   = (opcode == OP_MOVI);
        dec.has_mem    = (opcode == OP_LW) || (opcode == OP_SW);
        dec.has_mem_we = (opcode == OP_SW);
        dec.halt       = (opcode == OP_HALT);
        case (opcode)
            OP_MOV, OP_MOVI, OP_LW:            dec.has_we = 1'b1;
            // ALU groups write only for a known function code
            OP_BIT, OP_ARITH_U, OP_ARITH_S:    dec.has_we = (alu_op != ALU_NOP);
            default:                           dec.has_we = 1'b0;
        endcase
    end

endmodule

//--- design/vmicro16_regfile.sv
/* vmicro16 register file
   eight 16-bit registers, two asynchronous read ports and one write port */
`timescale 1ns/1ps

module vmicro16_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  vmicro16_pkg::reg_sel_t rs1,
    input  vmicro16_pkg::reg_sel_t rs2,
    output vmicro16_pkg::data_t    rd1,
    output vmicro16_pkg::data_t    rd2,
    input  logic                   wb_valid,
    input  vmicro16_pkg::wb_t      wb
);
    import vmicro16_pkg::*;

    data_t regs [NUM_REGS];

    // each register comes out of reset holding its own index
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= data_t'(i);
            end
        end else if (wb_valid) begin
            regs[wb.idx] <= wb.data;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

//--- design/vmicro16_fetch.sv
/* vmicro16 fetch and sequence unit
   program counter, instruction memory, instruction register and stage FSM */
`timescale 1ns/1ps

module vmicro16_fetch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  prog_we,
    input  vmicro16_pkg::pc_t     prog_addr,
    input  vmicro16_pkg::instr_t  prog_data,
    output vmicro16_pkg::stage_t  stage,
    output vmicro16_pkg::decoded_t dec,
    output logic                  halted
);
    import vmicro16_pkg::*;

    instr_t imem [INSTR_DEPTH];
    instr_t imem_q;
    instr_t ir;
    pc_t    pc;

    // program load port and registered read at pc
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
        if (stage == ST_FETCH) begin
            imem_q <= imem[pc];
        end
    end

    // instruction register and pc advance together in decode
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
        end else if (stage == ST_DECODE) begin
            ir <= imem_q;
            pc <= pc + 1'b1;
        end
    end

    // stage sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= ST_FETCH;
        end else begin
            case (stage)
                ST_FETCH:  stage <= ST_DECODE;
                ST_DECODE: stage <= ST_EXEC;
                ST_EXEC: begin
                    if (dec.halt) begin
                        stage <= ST_HALTED;
                    end else if (dec.has_mem) begin
                        stage <= ST_MEM;
                    end else begin
                        stage <= ST_FETCH;
                    end
                end
                ST_MEM:    stage <= ST_WB;
                ST_WB:     stage <= ST_FETCH;
                // only reset leaves the halted state
                ST_HALTED: stage <= ST_HALTED;
                default:   stage <= ST_FETCH;
            endcase
        end
    end

    assign halted = (stage == ST_HALTED);

    vmicro16_decoder u_decoder (
        .instr (ir),
        .dec   (dec)
    );

endmodule

//--- design/vmicro16_execute.sv
/* vmicro16 execute unit
   operand select, ALU, scratch data memory and write-back select */
`timescale 1ns/1ps

module vmicro16_execute (
    input  logic                   clk,
    input  vmicro16_pkg::stage_t   stage,
    input  vmicro16_pkg::decoded_t dec,
    output vmicro16_pkg::reg_sel_t rs1,
    output vmicro16_pkg::reg_sel_t rs2,
    input  vmicro16_pkg::data_t    rd1,
    input  vmicro16_pkg::data_t    rd2,
    output logic                   wb_valid,
    output vmicro16_pkg::wb_t      wb
);
    import vmicro16_pkg::*;

    data_t         op_b;
    data_t         alu_c;
    data_t         scratch [SCRATCH_DEPTH];
    data_t         load_q;
    scratch_addr_t mem_addr;
    logic          mem_access;

    // rd is the first operand and the store source, ra the second
    assign rs1 = dec.rd;
    assign rs2 = dec.ra;

    assign op_b = dec.has_imm8 ? {8'h00, dec.imm8} : rd2;

    vmicro16_alu u_alu (
        .op (dec.alu_op),
        .a  (rd1),
        .b  (op_b),
        .c  (alu_c)
    );

    // ra plus simm5, kept to the 6-bit scratch range
    assign mem_addr   = rd2[5:0] + {1'b0, dec.simm5};
    assign mem_access = (stage == ST_MEM) && dec.has_mem;

    // write-first scratch memory, a load result is held through ST_WB
    always_ff @(posedge clk) begin
        if (mem_access) begin
            if (dec.has_mem_we) begin
                scratch[mem_addr] <= rd1;
                load_q            <= rd1;
            end else begin
                load_q <= scratch[mem_addr];
            end
        end
    end

    // register ops commit in ST_EXEC, loads in ST_WB
    always_comb begin
        if (dec.has_mem) begin
            wb_valid = dec.has_we && (stage == ST_WB);
        end else begin
            wb_valid = dec.has_we && (stage == ST_EXEC);
        end
    end

    assign wb.idx  = dec.rd;
    assign wb.data = dec.has_mem ? load_q : alu_c;

endmodule

//--- design/vmicro16_top.sv
/* vmicro16 core top level
   joins the fetch sequencer, register file and execute unit */
`timescale 1ns/1ps

module vmicro16_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 prog_we,
    input  vmicro16_pkg::pc_t    prog_addr,
    input  vmicro16_pkg::instr_t prog_data,
    output logic                 wb_valid,
    output vmicro16_pkg::wb_t    wb,
    output logic                 halted
);
    import vmicro16_pkg::*;

    stage_t   stage;
    decoded_t dec;
    reg_sel_t rs1;
    reg_sel_t rs2;
    data_t    rd1;
    data_t    rd2;

    vmicro16_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .stage     (stage),
        .dec       (dec),
        .halted    (halted)
    );

    vmicro16_regfile u_regfile (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd1      (rd1),
        .rd2      (rd2),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    vmicro16_execute u_execute (
        .clk      (clk),
        .stage    (stage),
        .dec      (dec),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd1      (rd1),
        .rd2      (rd2),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

//--- dv/vmicro16_assert.sv
/* vmicro16 sequencer and write-back assertions, bound to the core top level */
`timescale 1ns/1ps

module vmicro16_assert (
    input logic clk,
    input logic reset,
    input logic wb_valid,
    input logic halted
);

    // a halted core commits nothing
    assert property (@(posedge clk) disable iff (reset) halted |-> !wb_valid)
        else $error("write-back seen while the core is halted");

    // only reset leaves the halted state
    assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted dropped without reset");

    // write-back is a single cycle strobe
    assert property (@(posedge clk) disable iff (reset) wb_valid |=> !wb_valid)
        else $error("wb_valid held high for two cycles");

endmodule

bind vmicro16_top vmicro16_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .wb_valid (wb_valid),
    .halted   (halted)
);

//--- dv/vmicro16_tb.sv
/* vmicro16 testbench
   loads directed programs, replays them on a reference model and compares write-backs */
`timescale 1ns/1ps

module vmicro16_tb;
    import vmicro16_pkg::*;

    localparam time CLK_PERIOD    = 100ns;
    localparam int  TOTAL_INSTR   = 80;
    localparam int  MARGIN_CYCLES = 300;

    logic   clk = 1'b0;
    logic   reset, prog_we, wb_valid, halted;
    pc_t    prog_addr;
    instr_t prog_data;
    wb_t    wb;

    instr_t      prog [$];
    wb_t         exp_wb [$];
    int          exp_cyc [$];
    int          exp_halt;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] seed = 32'hb297_3957;

    vmicro16_top UUT (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .wb_valid(wb_valid), .wb(wb), .halted(halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] rand_byte();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[23:16];
    endfunction

    function automatic instr_t asm_rr(logic [4:0] op, reg_sel_t rd, reg_sel_t ra, logic [4:0] f);
        return {op, rd, ra, f};
    endfunction

    function automatic instr_t asm_imm(logic [4:0] op, reg_sel_t rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic check_eq(string what, logic [31:0] got, logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                     $time, what, got, expected);
        end
    endtask

    // reference model giving the order, value and cycle of each write-back
    task automatic build_expected();
        data_t      regs [NUM_REGS];
        data_t      mem [SCRATCH_DEPTH];
        logic [4:0] op;
        reg_sel_t   rd, ra;
        logic [4:0] f;
        data_t      a, b, v;
        logic       we, done;
        int         t, len, addr;
        wb_t        ev;
        for (int i = 0; i < NUM_REGS; i++) regs[i] = data_t'(i);
        for (int i = 0; i < SCRATCH_DEPTH; i++) mem[i] = '0;
        exp_wb.delete();
        exp_cyc.delete();
        exp_halt = -1;
        t = 0;
        done = 1'b0;
        for (int n = 0; n < prog.size() && !done; n++) begin
            {op, rd, ra, f} = prog[n];
            a = regs[rd];
            b = regs[ra];
            we = 1'b0;
            len = 3;
            v = '0;
            addr = (int'(b) + int'(f)) % SCRATCH_DEPTH;
            case (op)
                OP_HALT: begin
                    exp_halt = t + 3;
                    done = 1'b1;
                end
                OP_MOV: begin
                    v = b;
                    we = 1'b1;
                end
                OP_MOVI: begin
                    v = {8'h00, prog[n][7:0]};
                    we = 1'b1;
                end
                OP_LW: begin
                    v = mem[addr];
                    we = 1'b1;
                    len = 5;
                end
                OP_SW: begin
                    mem[addr] = a;
                    len = 5;
                end
                OP_BIT: begin
                    we = 1'b1;
                    case (f)
                        FN_OR:    v = a | b;
                        FN_XOR:   v = a ^ b;
                        FN_AND:   v = a & b;
                        FN_NOT:   v = ~b;
                        FN_LSHFT: v = (b >= 16) ? '0 : a << b[3:0];
                        FN_RSHFT: v = (b >= 16) ? '0 : a >> b[3:0];
                        default:  we = 1'b0;
                    endcase
                end
                OP_ARITH_U, OP_ARITH_S: begin
                    we = (f == FN_ADD) || (f == FN_SUB);
                    v = (f == FN_ADD) ? a + b : a - b;
                end
                default: ;
            endcase
            if (we) begin
                ev.idx = rd;
                ev.data = v;
                exp_wb.push_back(ev);
                exp_cyc.push_back(t + len - 1);
                regs[rd] = v;
            end
            t += len;
        end
    endtask

    task automatic run_program(string name);
        wb_t act_wb [$];
        int  act_cyc [$];
        int  cyc, halt_cyc;
        $display("running %s", name);
        @(posedge clk);
        #1 reset = 1'b1;
        foreach (prog[n]) begin
            prog_we = 1'b1;
            prog_addr = pc_t'(n);
            prog_data = prog[n];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        build_expected();
        cyc = 0;
        halt_cyc = -1;
        // cycle 0 is the fetch of the first instruction
        while (halt_cyc < 0 || cyc < halt_cyc + 5) begin
            @(negedge clk);
            if (wb_valid) begin
                act_wb.push_back(wb);
                act_cyc.push_back(cyc);
            end
            if (halted && halt_cyc < 0) halt_cyc = cyc;
            cyc++;
        end
        check_eq({name, " wb event count"}, act_wb.size(), exp_wb.size());
        for (int i = 0; i < act_wb.size() && i < exp_wb.size(); i++) begin
            check_eq($sformatf("%s wb.idx[%0d]", name, i), act_wb[i].idx, exp_wb[i].idx);
            check_eq($sformatf("%s wb.data[%0d]", name, i), act_wb[i].data, exp_wb[i].data);
            check_eq($sformatf("%s wb cycle[%0d]", name, i), act_cyc[i], exp_cyc[i]);
        end
        check_eq({name, " halted cycle"}, halt_cyc, exp_halt);
    endtask

    task automatic test_reset_mov();
        prog.delete();
        for (int k = 1; k < NUM_REGS; k++) prog.push_back(asm_rr(OP_MOV, 0, k, 0));
        prog.push_back(asm_rr(OP_HALT, 0, 0, 0));
        run_program("reset values and MOV");
    endtask

    task automatic test_movi_arith();
        prog.delete();
        for (int it = 0; it < 2; it++) begin
            prog.push_back(asm_imm(OP_MOVI, 1, rand_byte()));
            prog.push_back(asm_imm(OP_MOVI, 4, 8'd8));
            prog.push_back(asm_rr(OP_BIT, 1, 4, FN_LSHFT));
            prog.push_back(asm_imm(OP_MOVI, 5, rand_byte()));
            prog.push_back(asm_rr(OP_BIT, 1, 5, FN_OR));
            prog.push_back(asm_imm(OP_MOVI, 2, rand_byte()));
            prog.push_back(asm_rr(OP_BIT, 2, 4, FN_LSHFT));
            prog.push_back(asm_rr(OP_MOV, 3, 1, 0));
            prog.push_back(asm_rr(OP_ARITH_U, 3, 2, FN_ADD));
            prog.push_back(asm_rr(OP_MOV, 3, 1, 0));
            prog.push_back(asm_rr(OP_ARITH_U, 3, 2, FN_SUB));
            prog.push_back(asm_rr(OP_MOV, 6, 2, 0));
            prog.push_back(asm_rr(OP_ARITH_S, 6, 1, FN_SUB));
            prog.push_back(asm_rr(OP_ARITH_S, 6, 2, FN_ADD));
        end
        prog.push_back(asm_rr(OP_HALT, 0, 0, 0));
        run_program("MOVI and arithmetic");
    endtask

    task automatic test_bitwise();
        prog.delete();
        prog.push_back(asm_imm(OP_MOVI, 1, rand_byte()));
        prog.push_back(asm_imm(OP_MOVI, 7, 8'd8));
        prog.push_back(asm_rr(OP_BIT, 1, 7, FN_LSHFT));
        prog.push_back(asm_imm(OP_MOVI, 6, rand_byte()));
        prog.push_back(asm_rr(OP_BIT, 1, 6, FN_OR));
        prog.push_back(asm_imm(OP_MOVI, 2, rand_byte()));
        prog.push_back(asm_imm(OP_MOVI, 5, rand_byte() % 20));
        prog.push_back(asm_rr(OP_MOV, 3, 1, 0));
        prog.push_back(asm_rr(OP_BIT, 3, 2, FN_XOR));
        prog.push_back(asm_rr(OP_BIT, 3, 1, FN_AND));
        prog.push_back(asm_rr(OP_BIT, 3, 2, FN_OR));
        prog.push_back(asm_rr(OP_BIT, 4, 1, FN_NOT));
        prog.push_back(asm_rr(OP_MOV, 3, 1, 0));
        prog.push_back(asm_rr(OP_BIT, 3, 5, FN_LSHFT));
        prog.push_back(asm_rr(OP_MOV, 3, 1, 0));
        prog.push_back(asm_rr(OP_BIT, 3, 5, FN_RSHFT));
        prog.push_back(asm_rr(OP_HALT, 0, 0, 0));
        run_program("bitwise and shifts");
    endtask

    task automatic test_store_load();
        prog.delete();
        prog.push_back(asm_imm(OP_MOVI, 1, rand_byte()));
        prog.push_back(asm_imm(OP_MOVI, 2, rand_byte()));
        prog.push_back(asm_imm(OP_MOVI, 3, rand_byte()));
        prog.push_back(asm_rr(OP_SW, 2, 1, 5'd3));
        prog.push_back(asm_rr(OP_SW, 3, 1, 5'd17));
        prog.push_back(asm_rr(OP_LW, 4, 1, 5'd3));
        prog.push_back(asm_rr(OP_LW, 5, 1, 5'd17));
        prog.push_back(asm_rr(OP_HALT, 0, 0, 0));
        run_program("store and load round trip");
    endtask

    task automatic test_timing();
        prog.delete();
        prog.push_back(asm_imm(OP_MOVI, 1, 8'h5a));
        prog.push_back(asm_imm(OP_MOVI, 2, 8'h33));
        prog.push_back(asm_rr(OP_NOP, 1, 2, 0));
        prog.push_back(asm_rr(5'h1a, 1, 2, 0));
        prog.push_back(asm_rr(OP_BIT, 1, 2, 5'h0a));
        prog.push_back(asm_rr(OP_ARITH_U, 1, 2, 5'h05));
        prog.push_back(asm_rr(OP_ARITH_S, 1, 2, 5'h01));
        prog.push_back(asm_rr(OP_SW, 2, 0, 5'd4));
        prog.push_back(asm_rr(OP_LW, 3, 0, 5'd4));
        prog.push_back(asm_rr(OP_MOV, 4, 3, 0));
        prog.push_back(asm_rr(OP_HALT, 0, 0, 0));
        // never reached once the core halts
        prog.push_back(asm_imm(OP_MOVI, 5, 8'hff));
        prog.push_back(asm_imm(OP_MOVI, 6, 8'hee));
        run_program("timing, unknown codes and HALT");
    endtask

    // run length bound from the instruction count
    initial begin
        #((TOTAL_INSTR * 5 + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the core did not halt in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        test_reset_mov();
        test_movi_arith();
        test_bitwise();
        test_store_load();
        test_timing();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vmicro16.f
design/vmicro16_pkg.sv
design/vmicro16_alu.sv
design/vmicro16_decoder.sv
design/vmicro16_regfile.sv
design/vmicro16_fetch.sv
design/vmicro16_execute.sv
design/vmicro16_top.sv
dv/vmicro16_assert.sv
dv/vmicro16_tb.sv

//--- Makefile
# Verilator build and run for the vmicro16 core
VERILATOR ?= verilator
TOP       ?= vmicro16_tb
FILELIST  ?= vmicro16.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
